/* bench/axil_sprite_memory.sv */
`default_nettype none

module axil_sprite_memory (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] araddr,
    input  wire         arvalid,
    output logic        arready = 1'b0,
    output logic [31:0] rdata = '0,
    output logic        rvalid = 1'b0,
    input  wire         rready,
    output int          read_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  lfsr;
    logic [31:0] addr_q;
    logic        ar_fire;
    logic        r_fire;
    logic        pending;   // Address taken, data not yet returned
    int          ar_delay;
    int          r_delay;

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic logic [31:0] word_at(input logic [29:0] w);
        return (32'(w) * 32'h9E37_79B9) ^ {w[15:0], w[29:14]};
    endfunction

    // Two LFSR bits give a delay of 0 to 3 cycles
    task automatic next_delay(output int d);
        lfsr = lfsr_next(lfsr);
        d = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        d = d + 2 * int'(lfsr[0]);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ar_fire    <= 1'b0;
            r_fire     <= 1'b0;
            read_count <= 0;
        end else begin
            ar_fire <= arvalid && arready;
            r_fire  <= rvalid && rready;
            if (arvalid && arready) begin
                addr_q     <= araddr;
                read_count <= read_count + 1;
            end
        end
    end

    // Outputs change on the falling edge only
    always @(negedge clk) begin
        if (rst) begin
            arready  = 1'b0;
            rvalid   = 1'b0;
            pending  = 1'b0;
            lfsr     = 8'd62;
            ar_delay = 0;
            r_delay  = 0;
        end else begin
            if (ar_fire) begin
                arready = 1'b0;
                pending = 1'b1;
                next_delay(r_delay);
            end else if (arvalid && !arready && !pending) begin
                if (ar_delay == 0) begin
                    arready = 1'b1;
                end else begin
                    ar_delay = ar_delay - 1;
                end
            end
            if (r_fire) begin
                rvalid  = 1'b0;
                pending = 1'b0;
                next_delay(ar_delay);
            end else if (pending && !rvalid) begin
                if (r_delay == 0) begin
                    rvalid = 1'b1;
                    rdata  = word_at(addr_q[31:2]);
                end else begin
                    r_delay = r_delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/sprite_blitter_tb.sv */
`default_nettype none

module sprite_blitter_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import blit_pkg::*;

    localparam int NUM_TESTS    = 8;
    localparam int DRAW_TIMEOUT = 20000;
    localparam int FRAME_PIXELS = int'(FB_WIDTH) * int'(FB_HEIGHT);

    logic         clk = 1'b0;
    logic         rst;
    addr_t        image_start;
    coord_t       image_x;
    coord_t       image_y;
    coord_t       image_width;
    pixel_depth_t depth;
    coord_t       width;
    coord_t       height;
    scale_t       scale_x;
    scale_t       scale_y;
    logic         mirror_x;
    logic         mirror_y;
    coord_t       screen_x;
    coord_t       screen_y;
    logic         draw;
    logic         busy;
    addr_t        araddr;
    logic         arvalid;
    logic         arready;
    word_t        rdata;
    logic         rvalid;
    logic         rready;
    coord_t       fb_x;
    coord_t       fb_y;
    colour_t      fb_colour;
    logic         fb_write;
    int           read_count;

    // Command in force for the reference model
    string cmd_name;
    int    cmd_start, cmd_ix, cmd_iy, cmd_iw, cmd_depth;
    int    cmd_x0, cmd_y0, cmd_w, cmd_h, cmd_sx, cmd_sy;
    bit    cmd_mx, cmd_my, cmd_busy_draw;

    bit          written [0:FRAME_PIXELS-1];
    int          write_count;
    int          word_changes;
    logic [29:0] last_word;
    bit          have_word;
    int          errors;
    int          tests;
    int          failed;

    always #20 clk = ~clk;

    sprite_blitter UUT (
        .clk            (clk),
        .rst            (rst),
        .image_start    (image_start),
        .image_x        (image_x),
        .image_y        (image_y),
        .image_width    (image_width),
        .depth          (depth),
        .width          (width),
        .height         (height),
        .scale_x        (scale_x),
        .scale_y        (scale_y),
        .mirror_x       (mirror_x),
        .mirror_y       (mirror_y),
        .screen_x       (screen_x),
        .screen_y       (screen_y),
        .draw           (draw),
        .busy           (busy),
        .m_axil_araddr  (araddr),
        .m_axil_arvalid (arvalid),
        .m_axil_arready (arready),
        .m_axil_rdata   (rdata),
        .m_axil_rvalid  (rvalid),
        .m_axil_rready  (rready),
        .fb_x           (fb_x),
        .fb_y           (fb_y),
        .fb_colour      (fb_colour),
        .fb_write       (fb_write)
    );

    axil_sprite_memory memory (
        .clk        (clk),
        .rst        (rst),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rready     (rready),
        .read_count (read_count)
    );

    function automatic logic [31:0] sheet_word(input logic [29:0] w);
        return (32'(w) * 32'h9E37_79B9) ^ {w[15:0], w[29:14]};
    endfunction

    // Screen pixel back to its bit address in the sheet
    function automatic int pixel_bit_addr(input int px, input int py);
        int lx;
        int ly;
        lx = px - cmd_x0;
        ly = py - cmd_y0;
        if (cmd_mx) lx = cmd_w * cmd_sx - 1 - lx;
        if (cmd_my) ly = cmd_h * cmd_sy - 1 - ly;
        return ((cmd_ix + lx / cmd_sx) + (cmd_iy + ly / cmd_sy) * cmd_iw) * cmd_depth;
    endfunction

    function automatic logic [29:0] pixel_word(input int px, input int py);
        logic [31:0] byte_addr;
        byte_addr = cmd_start + pixel_bit_addr(px, py) / 8;
        return byte_addr[31:2];
    endfunction

    function automatic int expected_colour(input int px, input int py);
        int bits;
        bits = pixel_bit_addr(px, py);
        return int'((sheet_word(pixel_word(px, py)) >> (bits % 32))
                    & ((32'd1 << cmd_depth) - 32'd1));
    endfunction

    function automatic bit inside_box(input int px, input int py);
        return px >= cmd_x0 && px < cmd_x0 + cmd_w * cmd_sx && px < int'(FB_WIDTH)
            && py >= cmd_y0 && py < cmd_y0 + cmd_h * cmd_sy && py < int'(FB_HEIGHT);
    endfunction

    function automatic int clipped_span(input int origin, input int span, input int limit);
        if (origin >= limit) return 0;
        return (origin + span > limit) ? limit - origin : span;
    endfunction

    task automatic report_mismatch(input string what, input int got, input int want);
        errors++;
        $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
    endtask

    assert property (@(posedge clk) rst |=> !busy && !arvalid && !rready && !fb_write)
        else begin
            errors++;
            $display("%0t ns: outputs not idle after reset", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        fb_write |-> int'(fb_colour) == expected_colour(fb_x, fb_y))
        else report_mismatch("fb_colour", $sampled(fb_colour),
                             expected_colour($sampled(fb_x), $sampled(fb_y)));

    assert property (@(posedge clk) disable iff (rst) fb_write |-> inside_box(fb_x, fb_y))
        else begin
            errors++;
            $display("%0t ns: write at (%0d, %0d) lies outside the frame or the rectangle",
                     $time, $sampled(fb_x), $sampled(fb_y));
        end

    assert property (@(posedge clk) disable iff (rst) arvalid |-> araddr[1:0] == 2'b00)
        else report_mismatch("araddr low bits", $sampled(araddr[1:0]), 0);

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            errors++;
            $display("%0t ns: AR request changed before arready", $time);
        end

    // Write bookkeeping on the falling edge where outputs are settled
    always @(negedge clk) begin
        int idx;
        if (!rst && fb_write) begin
            idx = int'(fb_y) * int'(FB_WIDTH) + int'(fb_x);
            if (fb_x < FB_WIDTH && fb_y < FB_HEIGHT) begin
                assert (!written[idx])
                    else begin
                        errors++;
                        $display("%0t ns: pixel (%0d, %0d) written twice", $time, fb_x, fb_y);
                    end
                written[idx] = 1'b1;
            end
            write_count++;
            if (!have_word || pixel_word(fb_x, fb_y) != last_word) word_changes++;
            last_word = pixel_word(fb_x, fb_y);
            have_word = 1'b1;
        end
    end

    task automatic set_command(input string name, input int start, ix, iy, iw, d,
                               x0, y0, w, h, sx, sy, input bit mx, my, extra);
        cmd_name  = name;
        cmd_start = start;
        cmd_ix    = ix;
        cmd_iy    = iy;
        cmd_iw    = iw;
        cmd_depth = d;
        cmd_x0    = x0;
        cmd_y0    = y0;
        cmd_w     = w;
        cmd_h     = h;
        cmd_sx    = sx;
        cmd_sy    = sy;
        cmd_mx    = mx;
        cmd_my    = my;
        cmd_busy_draw = extra;
    endtask

    task automatic load_command(input int t);
        case (t)
            0: set_command("depth 1", 'h1000, 5, 3, 64, 1, 10, 12, 20, 5, 1, 1, 0, 0, 0);
            1: set_command("depth 2 mirror x", 'h2000, 2, 1, 40, 2, 100, 50, 6, 4, 3, 2, 1, 0, 0);
            2: set_command("depth 4 mirror y", 'h3000, 9, 4, 33, 4, 200, 100, 7, 5, 2, 3, 0, 1, 0);
            3: set_command("depth 8 mirror xy", 'h4000, 1, 2, 21, 8, 0, 0, 5, 6, 2, 2, 1, 1, 0);
            4: set_command("depth 16", 'h5000, 3, 7, 17, 16, 300, 200, 4, 4, 1, 3, 0, 0, 0);
            5: set_command("clip right bottom", 'h4000, 0, 0, 21, 8, 390, 232, 10, 6, 2, 2,
                           1, 0, 0);
            6: set_command("scale zero", 'h1000, 0, 0, 64, 1, 20, 20, 4, 4, 0, 2, 0, 0, 0);
            default: set_command("draw while busy", 'h3000, 0, 0, 33, 4, 50, 60, 8, 6, 2, 1,
                                 0, 0, 1);
        endcase
    endtask

    task automatic run_draw(output bit timed_out);
        int errors_before;
        int reads_before;
        int cycles;
        int expected;
        timed_out     = 1'b0;
        errors_before = errors;
        reads_before  = read_count;
        foreach (written[i]) written[i] = 1'b0;
        write_count  = 0;
        word_changes = 0;
        have_word    = 1'b0;
        image_start = addr_t'(cmd_start);
        image_x     = coord_t'(cmd_ix);
        image_y     = coord_t'(cmd_iy);
        image_width = coord_t'(cmd_iw);
        depth       = pixel_depth_t'(cmd_depth);
        screen_x    = coord_t'(cmd_x0);
        screen_y    = coord_t'(cmd_y0);
        width       = coord_t'(cmd_w);
        height      = coord_t'(cmd_h);
        scale_x     = scale_t'(cmd_sx);
        scale_y     = scale_t'(cmd_sy);
        mirror_x    = cmd_mx;
        mirror_y    = cmd_my;
        draw        = 1'b1;
        @(negedge clk);
        draw   = 1'b0;
        cycles = 0;
        while (busy && cycles < DRAW_TIMEOUT) begin
            if (cmd_busy_draw && cycles == 4) begin
                screen_x = screen_x + 16'd37;  // Must have no effect
                scale_x  = 16'd1;
                mirror_y = !mirror_y;
            end
            draw = cmd_busy_draw && cycles >= 4; // Held for the rest of the run
            @(negedge clk);
            cycles++;
        end
        draw = 1'b0;
        if (busy) begin
            timed_out = 1'b1;
            $display("Timeout: busy still high after %0d cycles in test %s", cycles, cmd_name);
        end else begin
            expected = clipped_span(cmd_x0, cmd_w * cmd_sx, int'(FB_WIDTH))
                     * clipped_span(cmd_y0, cmd_h * cmd_sy, int'(FB_HEIGHT));
            assert (write_count == expected)
                else report_mismatch("write count", write_count, expected);
            assert (read_count - reads_before == word_changes)
                else report_mismatch("AR transfer count", read_count - reads_before,
                                     word_changes);
            tests++;
            if (errors != errors_before) failed++;
            $display("test %s: %0d writes, %0d bus reads, %s", cmd_name, write_count,
                     read_count - reads_before, errors == errors_before ? "ok" : "FAIL");
        end
    endtask

    initial begin
        bit timed_out;
        int errors_before;
        timed_out = 1'b0;
        errors = 0;
        tests  = 0;
        failed = 0;
        rst         = 1'b1;
        draw        = 1'b0;
        image_start = '0;
        image_x     = '0;
        image_y     = '0;
        image_width = '0;
        depth       = DEPTH_8;
        width       = '0;
        height      = '0;
        scale_x     = '0;
        scale_y     = '0;
        mirror_x    = 1'b0;
        mirror_y    = 1'b0;
        screen_x    = '0;
        screen_y    = '0;
        set_command("none", 0, 0, 0, 1, 1, 0, 0, 0, 0, 1, 1, 0, 0, 0);
        errors_before = errors;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        tests++;
        if (errors != errors_before) failed++;
        $display("test reset state: %s", errors == errors_before ? "ok" : "FAIL");

        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            load_command(t);
            run_draw(timed_out);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (timed_out || errors != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/address_buffer.sv */
`default_nettype none

module address_buffer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire blit_pkg::addr_t       image_start,
    input  wire blit_pkg::coord_t      image_width,
    input  wire blit_pkg::pixel_depth_t depth,
    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire blit_pkg::coord_t      sheet_x,
    input  wire blit_pkg::coord_t      sheet_y,
    input  wire blit_pkg::coord_t      screen_x,
    input  wire blit_pkg::coord_t      screen_y,
    output logic                       out_valid,
    input  wire                        out_ready,
    output blit_pkg::addr_t            byte_addr,
    output blit_pkg::bit_offset_t      bit_offset,
    output blit_pkg::coord_t           fb_x,
    output blit_pkg::coord_t           fb_y,
    output logic                       idle
);
    import blit_pkg::*;

    buffer_state_t state;

    logic        s1_valid;
    addr_t       s1_index;   // Linear pixel index in the sheet
    coord_t      s1_fb_x;
    coord_t      s1_fb_y;
    addr_t       bit_addr;
    addr_t       s2_addr;
    logic        spill_valid;
    addr_t       spill_addr;
    bit_offset_t spill_offset;
    coord_t      spill_fb_x;
    coord_t      spill_fb_y;
    logic        in_fire;
    logic        out_fire;
    logic        out_free;
    logic        s1_move;
    logic        s1_to_spill;

    // Output fills before the spill slot does
    assign out_valid   = !(state == B_EMPTY || (state == B_ONE && s1_valid));
    assign spill_valid = state == B_SPILL || (state == B_TWO && !s1_valid);
    assign in_ready    = !spill_valid;
    assign idle        = state == B_EMPTY;

    assign in_fire     = in_valid && in_ready;
    assign out_fire    = out_valid && out_ready;
    assign out_free    = !out_valid || out_ready;
    assign s1_move     = s1_valid && (out_free || !spill_valid);
    assign s1_to_spill = s1_valid && ((out_free && spill_valid) || (!out_free && !spill_valid));

    assign bit_addr = s1_index * addr_t'(depth);
    assign s2_addr  = image_start + (bit_addr >> 3);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= B_EMPTY;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_fire || (s1_valid && !s1_move);
            if (in_fire && !out_fire) begin
                state <= buffer_state_t'(state + 2'd1);
            end else if (out_fire && !in_fire) begin
                state <= buffer_state_t'(state - 2'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            s1_index <= addr_t'(sheet_x) + addr_t'(sheet_y) * addr_t'(image_width);
            s1_fb_x  <= screen_x;
            s1_fb_y  <= screen_y;
        end

        if (out_free && spill_valid) begin
            byte_addr  <= spill_addr;
            bit_offset <= spill_offset;
            fb_x       <= spill_fb_x;
            fb_y       <= spill_fb_y;
        end else if (out_free && s1_valid) begin
            byte_addr  <= s2_addr;
            bit_offset <= bit_addr[4:0];
            fb_x       <= s1_fb_x;
            fb_y       <= s1_fb_y;
        end

        if (s1_to_spill) begin
            spill_addr   <= s2_addr;
            spill_offset <= bit_addr[4:0];
            spill_fb_x   <= s1_fb_x;
            spill_fb_y   <= s1_fb_y;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable({byte_addr, bit_offset, fb_x, fb_y}));

endmodule

`default_nettype wire

/* hdl/blit_pkg.sv */
`default_nettype none

package blit_pkg;

    typedef logic [15:0] coord_t;      // Screen or sheet position, sizes
    typedef logic [15:0] scale_t;
    typedef logic [31:0] addr_t;       // Byte address
    typedef logic [31:0] word_t;
    typedef logic [15:0] colour_t;
    typedef logic [4:0]  bit_offset_t; // Bit position inside a 32-bit word

    typedef enum logic [4:0] {
        DEPTH_1  = 5'd1,
        DEPTH_2  = 5'd2,
        DEPTH_4  = 5'd4,
        DEPTH_8  = 5'd8,
        DEPTH_16 = 5'd16
    } pixel_depth_t;

    localparam coord_t FB_WIDTH  = 16'd400;
    localparam coord_t FB_HEIGHT = 16'd240;

    typedef enum logic {
        W_IDLE,
        W_WALKING
    } walker_state_t;

    // Number of items held including stage one
    typedef enum logic [1:0] {
        B_EMPTY = 2'd0,
        B_ONE   = 2'd1,
        B_TWO   = 2'd2,
        B_SPILL = 2'd3
    } buffer_state_t;

    typedef enum logic [1:0] {
        F_IDLE,
        F_ADDRESS,
        F_DATA,
        F_WRITE
    } fetch_state_t;

endpackage

`default_nettype wire

/* hdl/pixel_fetch.sv */
`default_nettype none

module pixel_fetch (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        draw_start,
    input  wire blit_pkg::pixel_depth_t depth,
    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire blit_pkg::addr_t       byte_addr,
    input  wire blit_pkg::bit_offset_t bit_offset,
    input  wire blit_pkg::coord_t      fb_x_in,
    input  wire blit_pkg::coord_t      fb_y_in,
    output logic                       arvalid,
    input  wire                        arready,
    output blit_pkg::addr_t            araddr,
    input  wire                        rvalid,
    output logic                       rready,
    input  wire blit_pkg::word_t       rdata,
    output blit_pkg::coord_t           fb_x,
    output blit_pkg::coord_t           fb_y,
    output blit_pkg::colour_t          fb_colour,
    output logic                       fb_write,
    output logic                       idle
);
    import blit_pkg::*;

    fetch_state_t state;

    logic [29:0] cache_word;   // Word address of the cached data
    logic        cache_valid;
    word_t       cache_data;
    bit_offset_t offset_q;
    logic        in_fire;
    logic        r_fire;
    logic        hit;

    // First pixel sits in the low bits of a word
    function automatic colour_t extract(word_t w, bit_offset_t off, pixel_depth_t d);
        word_t mask;
        mask = (word_t'(1) << d) - word_t'(1);
        return colour_t'((w >> off) & mask);
    endfunction

    assign in_ready = state == F_IDLE;
    assign idle     = state == F_IDLE;
    assign arvalid  = state == F_ADDRESS;
    assign rready   = state == F_DATA;
    assign fb_write = state == F_WRITE;

    assign in_fire = in_valid && in_ready;
    assign r_fire  = rvalid && rready;
    assign hit     = cache_valid && cache_word == byte_addr[31:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= F_IDLE;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (in_fire) begin
                        state <= hit ? F_WRITE : F_ADDRESS;
                    end
                end
                F_ADDRESS: begin
                    if (arready) begin
                        state <= F_DATA;
                    end
                end
                F_DATA: begin
                    if (rvalid) begin
                        state       <= F_WRITE;
                        cache_valid <= 1'b1;
                    end
                end
                F_WRITE: state <= F_IDLE;
                default: state <= F_IDLE;
            endcase
            if (draw_start) begin
                cache_valid <= 1'b0; // Sheet may have changed
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            fb_x      <= fb_x_in;
            fb_y      <= fb_y_in;
            offset_q  <= bit_offset;
            araddr    <= {byte_addr[31:2], 2'b00};
            fb_colour <= extract(cache_data, bit_offset, depth); // Kept only on a hit
        end
        if (r_fire) begin
            cache_data <= rdata;
            cache_word <= araddr[31:2];
            fb_colour  <= extract(rdata, offset_q, depth);
        end
    end

    // AR request held stable until accepted
    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

/* hdl/rect_walker.sv */
`default_nettype none

module rect_walker (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  draw,
    input  wire blit_pkg::coord_t image_x,
    input  wire blit_pkg::coord_t image_y,
    input  wire blit_pkg::coord_t screen_x0,
    input  wire blit_pkg::coord_t screen_y0,
    input  wire blit_pkg::coord_t width,
    input  wire blit_pkg::coord_t height,
    input  wire blit_pkg::scale_t scale_x,
    input  wire blit_pkg::scale_t scale_y,
    input  wire                  mirror_x,
    input  wire                  mirror_y,
    output logic                 idle,
    output blit_pkg::coord_t     sheet_x,
    output blit_pkg::coord_t     sheet_y,
    output blit_pkg::coord_t     screen_x,
    output blit_pkg::coord_t     screen_y,
    output logic                 valid,
    input  wire                  ready
);
    import blit_pkg::*;

    walker_state_t state;

    coord_t x0;
    coord_t y0;
    coord_t sheet_x0;
    coord_t last_x;      // Last local position of the scaled box
    coord_t last_y;
    scale_t last_sub_x;
    scale_t last_sub_y;
    logic   flip_x;
    logic   flip_y;
    coord_t x;
    coord_t y;
    scale_t sub_x;
    scale_t sub_y;
    logic   in_frame;
    logic   step;
    logic   empty_cmd;

    assign empty_cmd = scale_x == '0 || scale_y == '0 || width == '0 || height == '0;

    assign screen_x = flip_x ? x0 + last_x - x : x0 + x;
    assign screen_y = flip_y ? y0 + last_y - y : y0 + y;
    assign in_frame = screen_x < FB_WIDTH && screen_y < FB_HEIGHT;

    assign idle  = state == W_IDLE;
    assign valid = state == W_WALKING && in_frame;
    // Clipped positions advance without a transfer
    assign step  = state == W_WALKING && (ready || !in_frame);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (draw && !empty_cmd) begin
                        state <= W_WALKING;
                    end
                end
                W_WALKING: begin
                    if (step && x == last_x && y == last_y) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && draw) begin
            x0         <= screen_x0;
            y0         <= screen_y0;
            sheet_x0   <= image_x;
            last_x     <= width * scale_x - 16'd1;
            last_y     <= height * scale_y - 16'd1;
            last_sub_x <= scale_x - 16'd1;
            last_sub_y <= scale_y - 16'd1;
            flip_x     <= mirror_x;
            flip_y     <= mirror_y;
            x          <= '0;
            y          <= '0;
            sub_x      <= '0;
            sub_y      <= '0;
            sheet_x    <= image_x;
            sheet_y    <= image_y;
        end else if (step) begin
            if (x == last_x) begin
                // End of a screen row
                x       <= '0;
                sub_x   <= '0;
                sheet_x <= sheet_x0;
                y       <= y + 16'd1;
                if (sub_y == last_sub_y) begin
                    sub_y   <= '0;
                    sheet_y <= sheet_y + 16'd1;
                end else begin
                    sub_y <= sub_y + 16'd1;
                end
            end else begin
                x <= x + 16'd1;
                if (sub_x == last_sub_x) begin
                    sub_x   <= '0;
                    sheet_x <= sheet_x + 16'd1; // Next sheet column
                end else begin
                    sub_x <= sub_x + 16'd1;
                end
            end
        end
    end

    // A stalled coordinate holds until taken
    assert property (@(posedge clk) disable iff (rst)
        valid && !ready |=> valid && $stable({sheet_x, sheet_y, screen_x, screen_y}));

endmodule

`default_nettype wire

/* hdl/sprite_blitter.sv */
`default_nettype none

module sprite_blitter (
    input  wire                        clk,
    input  wire                        rst,
    input  wire blit_pkg::addr_t       image_start,
    input  wire blit_pkg::coord_t      image_x,
    input  wire blit_pkg::coord_t      image_y,
    input  wire blit_pkg::coord_t      image_width,
    input  wire blit_pkg::pixel_depth_t depth,
    input  wire blit_pkg::coord_t      width,
    input  wire blit_pkg::coord_t      height,
    input  wire blit_pkg::scale_t      scale_x,
    input  wire blit_pkg::scale_t      scale_y,
    input  wire                        mirror_x,
    input  wire                        mirror_y,
    input  wire blit_pkg::coord_t      screen_x,
    input  wire blit_pkg::coord_t      screen_y,
    input  wire                        draw,
    output logic                       busy,
    output blit_pkg::addr_t            m_axil_araddr,
    output logic                       m_axil_arvalid,
    input  wire                        m_axil_arready,
    input  wire blit_pkg::word_t       m_axil_rdata,
    input  wire                        m_axil_rvalid,
    output logic                       m_axil_rready,
    output blit_pkg::coord_t           fb_x,
    output blit_pkg::coord_t           fb_y,
    output blit_pkg::colour_t          fb_colour,
    output logic                       fb_write
);
    import blit_pkg::*;

    logic        draw_start;
    logic        walker_idle;
    logic        buffer_idle;
    logic        fetch_idle;
    coord_t      w_sheet_x;
    coord_t      w_sheet_y;
    coord_t      w_screen_x;
    coord_t      w_screen_y;
    logic        w_valid;
    logic        w_ready;
    addr_t       b_byte_addr;
    bit_offset_t b_bit_offset;
    coord_t      b_fb_x;
    coord_t      b_fb_y;
    logic        b_valid;
    logic        b_ready;

    assign busy       = !(walker_idle && buffer_idle && fetch_idle);
    assign draw_start = draw && !busy; // Draw while busy is dropped

    rect_walker walker (
        .clk       (clk),
        .rst       (rst),
        .draw      (draw_start),
        .image_x   (image_x),
        .image_y   (image_y),
        .screen_x0 (screen_x),
        .screen_y0 (screen_y),
        .width     (width),
        .height    (height),
        .scale_x   (scale_x),
        .scale_y   (scale_y),
        .mirror_x  (mirror_x),
        .mirror_y  (mirror_y),
        .idle      (walker_idle),
        .sheet_x   (w_sheet_x),
        .sheet_y   (w_sheet_y),
        .screen_x  (w_screen_x),
        .screen_y  (w_screen_y),
        .valid     (w_valid),
        .ready     (w_ready)
    );

    address_buffer buffer (
        .clk         (clk),
        .rst         (rst),
        .image_start (image_start),
        .image_width (image_width),
        .depth       (depth),
        .in_valid    (w_valid),
        .in_ready    (w_ready),
        .sheet_x     (w_sheet_x),
        .sheet_y     (w_sheet_y),
        .screen_x    (w_screen_x),
        .screen_y    (w_screen_y),
        .out_valid   (b_valid),
        .out_ready   (b_ready),
        .byte_addr   (b_byte_addr),
        .bit_offset  (b_bit_offset),
        .fb_x        (b_fb_x),
        .fb_y        (b_fb_y),
        .idle        (buffer_idle)
    );

    pixel_fetch fetch (
        .clk        (clk),
        .rst        (rst),
        .draw_start (draw_start),
        .depth      (depth),
        .in_valid   (b_valid),
        .in_ready   (b_ready),
        .byte_addr  (b_byte_addr),
        .bit_offset (b_bit_offset),
        .fb_x_in    (b_fb_x),
        .fb_y_in    (b_fb_y),
        .arvalid    (m_axil_arvalid),
        .arready    (m_axil_arready),
        .araddr     (m_axil_araddr),
        .rvalid     (m_axil_rvalid),
        .rready     (m_axil_rready),
        .rdata      (m_axil_rdata),
        .fb_x       (fb_x),
        .fb_y       (fb_y),
        .fb_colour  (fb_colour),
        .fb_write   (fb_write),
        .idle       (fetch_idle)
    );

endmodule

`default_nettype wire

/* sprite_blitter.f */
hdl/blit_pkg.sv
hdl/rect_walker.sv
hdl/address_buffer.sv
hdl/pixel_fetch.sv
hdl/sprite_blitter.sv
bench/axil_sprite_memory.sv
bench/sprite_blitter_tb.sv
